// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 32;
    localparam logic [11:0] CSR_TOHOST = 12'h51e;
    localparam int DMEM_WORDS = 64;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_ARI_ITYPE = 7'b0010011,
        OPC_ARI_RTYPE = 7'b0110011,
        OPC_CSR       = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_A_PLUS_4,
        ALU_BSEL
    } alu_op_e;

    typedef enum logic {A_REG, A_PC} a_sel_e;
    typedef enum logic {B_REG, B_IMM} b_sel_e;
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;
    typedef enum logic {CSR_RS1, CSR_IMM} csr_sel_e;

    // Arithmetic funct3
    localparam logic [2:0] FNC_ADD_SUB = 3'b000;
    localparam logic [2:0] FNC_SLL     = 3'b001;
    localparam logic [2:0] FNC_SLT     = 3'b010;
    localparam logic [2:0] FNC_SLTU    = 3'b011;
    localparam logic [2:0] FNC_XOR     = 3'b100;
    localparam logic [2:0] FNC_SRL_SRA = 3'b101;
    localparam logic [2:0] FNC_OR      = 3'b110;
    localparam logic [2:0] FNC_AND     = 3'b111;

    // Branch conditions
    localparam logic [2:0] FNC_BEQ  = 3'b000;
    localparam logic [2:0] FNC_BNE  = 3'b001;
    localparam logic [2:0] FNC_BLT  = 3'b100;
    localparam logic [2:0] FNC_BGE  = 3'b101;
    localparam logic [2:0] FNC_BLTU = 3'b110;
    localparam logic [2:0] FNC_BGEU = 3'b111;

    // Load and store widths
    localparam logic [2:0] FNC_LB  = 3'b000;
    localparam logic [2:0] FNC_LH  = 3'b001;
    localparam logic [2:0] FNC_LW  = 3'b010;
    localparam logic [2:0] FNC_LBU = 3'b100;
    localparam logic [2:0] FNC_LHU = 3'b101;
    localparam logic [2:0] FNC_SB  = 3'b000;
    localparam logic [2:0] FNC_SH  = 3'b001;
    localparam logic [2:0] FNC_SW  = 3'b010;

    localparam logic [2:0] FNC_CSRRW  = 3'b001;
    localparam logic [2:0] FNC_CSRRWI = 3'b101;

endpackage

// ==== verilog/ex_control.sv ====
`timescale 1ns/1ps

module ex_control (
    input  logic             [31:0] inst,
    input  logic             [31:0] mem_inst,
    input  logic             [31:0] wb_inst,
    input  logic                    breq,
    input  logic                    brlt,
    input  logic                    br_taken,
    output logic                    brun,
    output rv_pkg::fwd_sel_e        fwda,
    output rv_pkg::fwd_sel_e        fwdb,
    output rv_pkg::a_sel_e          asel,
    output rv_pkg::b_sel_e          bsel,
    output rv_pkg::csr_sel_e        csr_mux_sel,
    output logic                    csr_en,
    output logic                    br_mispred,
    output rv_pkg::alu_op_e         alusel
);
    import rv_pkg::*;

    opcode_e    opcode;
    opcode_e    mem_opcode;
    opcode_e    wb_opcode;
    logic [2:0] funct3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       has_rs1;
    logic       has_rs2;
    logic       mem_has_rd;
    logic       wb_has_rd;
    logic       br_outcome;

    assign opcode     = opcode_e'(inst[6:0]);
    assign mem_opcode = opcode_e'(mem_inst[6:0]);
    assign wb_opcode  = opcode_e'(wb_inst[6:0]);
    assign funct3     = inst[14:12];
    assign rs1        = inst[19:15];
    assign rs2        = inst[24:20];

    assign has_rs1 = opcode != OPC_LUI && opcode != OPC_AUIPC && opcode != OPC_JAL
                  && (opcode != OPC_CSR || funct3 == FNC_CSRRW) && rs1 != 5'd0;
    assign has_rs2 = (opcode == OPC_ARI_RTYPE || opcode == OPC_STORE || opcode == OPC_BRANCH)
                  && rs2 != 5'd0;

    assign mem_has_rd = mem_opcode != OPC_STORE && mem_opcode != OPC_BRANCH
                     && mem_opcode != OPC_CSR;
    assign wb_has_rd  = wb_opcode != OPC_STORE && wb_opcode != OPC_BRANCH
                     && wb_opcode != OPC_CSR;

    // Younger result in MEM wins over WB
    assign fwda = (has_rs1 && mem_has_rd && rs1 == mem_inst[11:7]) ? FWD_MEM :
                  (has_rs1 && wb_has_rd && rs1 == wb_inst[11:7])   ? FWD_WB  : FWD_NONE;
    assign fwdb = (has_rs2 && mem_has_rd && rs2 == mem_inst[11:7]) ? FWD_MEM :
                  (has_rs2 && wb_has_rd && rs2 == wb_inst[11:7])   ? FWD_WB  : FWD_NONE;

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
                                         input logic rtype);
        case (f3)
            FNC_ADD_SUB: return (rtype && alt) ? ALU_SUB : ALU_ADD;
            FNC_SLL:     return ALU_SLL;
            FNC_SLT:     return ALU_SLT;
            FNC_SLTU:    return ALU_SLTU;
            FNC_XOR:     return ALU_XOR;
            FNC_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            FNC_OR:      return ALU_OR;
            FNC_AND:     return ALU_AND;
            default:     return ALU_ADD;
        endcase
    endfunction

    // Resolved branch direction
    always_comb begin
        brun = funct3 == FNC_BLTU || funct3 == FNC_BGEU;
        case (funct3)
            FNC_BEQ:            br_outcome = breq;
            FNC_BNE:            br_outcome = !breq;
            FNC_BLT, FNC_BLTU:  br_outcome = brlt;
            FNC_BGE, FNC_BGEU:  br_outcome = !brlt;
            default:            br_outcome = br_taken;
        endcase
    end

    always_comb begin
        asel        = A_REG;
        bsel        = B_REG;
        alusel      = ALU_ADD;
        csr_mux_sel = CSR_RS1;
        csr_en      = 1'b0;
        br_mispred  = 1'b0;

        case (opcode)
            OPC_ARI_RTYPE: alusel = arith_op(funct3, inst[30], 1'b1);
            OPC_ARI_ITYPE: begin
                bsel   = B_IMM;
                alusel = arith_op(funct3, inst[30], 1'b0);
            end
            OPC_LOAD: begin
                if (funct3 inside {FNC_LB, FNC_LH, FNC_LW, FNC_LBU, FNC_LHU}) begin
                    bsel = B_IMM;
                end
            end
            OPC_STORE: begin
                if (funct3 inside {FNC_SB, FNC_SH, FNC_SW}) begin
                    bsel = B_IMM;
                end
            end
            OPC_BRANCH: begin
                asel = A_PC;
                bsel = B_IMM;
                if (br_outcome != br_taken) begin
                    br_mispred = 1'b1;
                    alusel     = br_outcome ? ALU_ADD : ALU_A_PLUS_4;
                end
            end
            OPC_JAL, OPC_JALR: begin
                asel   = A_PC;
                alusel = ALU_A_PLUS_4;
            end
            OPC_LUI: begin
                bsel   = B_IMM;
                alusel = ALU_BSEL;
            end
            OPC_AUIPC: begin
                asel = A_PC;
                bsel = B_IMM;
            end
            OPC_CSR: begin
                csr_en      = funct3 == FNC_CSRRW || funct3 == FNC_CSRRWI;
                csr_mux_sel = (funct3 == FNC_CSRRWI) ? CSR_IMM : CSR_RS1;
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  logic [31:0]             inst,
    input  logic [rv_pkg::XLEN-1:0] pc,
    input  logic                    pred_taken,
    input  logic                    kill,
    input  logic                    wb_valid,
    input  logic [4:0]              wb_rd,
    input  logic [rv_pkg::XLEN-1:0] wb_data,
    output logic                    ex_valid,
    output logic [31:0]             ex_inst,
    output logic [rv_pkg::XLEN-1:0] ex_pc,
    output logic                    ex_pred_taken,
    output logic [rv_pkg::XLEN-1:0] ex_rs1_val,
    output logic [rv_pkg::XLEN-1:0] ex_rs2_val,
    output logic [rv_pkg::XLEN-1:0] ex_imm
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31];
    opcode_e         opcode;
    logic            accept;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] imm;

    assign opcode = opcode_e'(inst[6:0]);
    assign accept = in_valid && !kill;

    // x0 reads zero and a same-cycle retire is bypassed
    function automatic logic [XLEN-1:0] read_reg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wb_valid && wb_rd == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_valid && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb begin
        rs1_val = read_reg(inst[19:15]);
        rs2_val = read_reg(inst[24:20]);
    end

    always_comb begin
        case (opcode)
            OPC_LOAD, OPC_ARI_ITYPE, OPC_JALR:
                imm = {{20{inst[31]}}, inst[31:20]};
            OPC_STORE:
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OPC_BRANCH:
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm = {inst[31:12], 12'b0};
            OPC_JAL:
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            // Zero-extended uimm for CSRRWI
            OPC_CSR:
                imm = {27'b0, inst[19:15]};
            default:
                imm = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
            ex_inst  <= '0;
        end else begin
            ex_valid <= accept;
            ex_inst  <= accept ? inst : '0;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc         <= pc;
        ex_pred_taken <= pred_taken;
        ex_rs1_val    <= rs1_val;
        ex_rs2_val    <= rs2_val;
        ex_imm        <= imm;
    end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    ex_valid,
    input  logic [31:0]             ex_inst,
    input  logic [rv_pkg::XLEN-1:0] ex_pc,
    input  logic                    ex_pred_taken,
    input  logic [rv_pkg::XLEN-1:0] ex_rs1_val,
    input  logic [rv_pkg::XLEN-1:0] ex_rs2_val,
    input  logic [rv_pkg::XLEN-1:0] ex_imm,
    input  logic [rv_pkg::XLEN-1:0] mem_fwd_val,
    input  logic [rv_pkg::XLEN-1:0] wb_fwd_val,
    input  logic [31:0]             mem_inst,
    input  logic [31:0]             wb_inst,
    output logic                    mem_valid,
    output logic [31:0]             mem_inst_q,
    output logic [rv_pkg::XLEN-1:0] mem_alu,
    output logic [rv_pkg::XLEN-1:0] mem_store_data,
    output logic                    redirect,
    output logic [rv_pkg::XLEN-1:0] redirect_pc,
    output logic [rv_pkg::XLEN-1:0] tohost
);
    import rv_pkg::*;

    logic            brun;
    logic            breq;
    logic            brlt;
    fwd_sel_e        fwda;
    fwd_sel_e        fwdb;
    a_sel_e          asel;
    b_sel_e          bsel;
    csr_sel_e        csr_mux_sel;
    logic            csr_en;
    logic            br_mispred;
    alu_op_e         alusel;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;

    ex_control ctrl_i (
        .inst        (ex_inst),
        .mem_inst    (mem_inst),
        .wb_inst     (wb_inst),
        .breq        (breq),
        .brlt        (brlt),
        .br_taken    (ex_pred_taken),
        .brun        (brun),
        .fwda        (fwda),
        .fwdb        (fwdb),
        .asel        (asel),
        .bsel        (bsel),
        .csr_mux_sel (csr_mux_sel),
        .csr_en      (csr_en),
        .br_mispred  (br_mispred),
        .alusel      (alusel)
    );

    assign rs1 = (fwda == FWD_MEM) ? mem_fwd_val : (fwda == FWD_WB) ? wb_fwd_val : ex_rs1_val;
    assign rs2 = (fwdb == FWD_MEM) ? mem_fwd_val : (fwdb == FWD_WB) ? wb_fwd_val : ex_rs2_val;

    assign breq = rs1 == rs2;
    assign brlt = brun ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));

    assign op_a = (asel == A_PC) ? ex_pc : rs1;
    assign op_b = (bsel == B_IMM) ? ex_imm : rs2;

    always_comb begin
        case (alusel)
            ALU_ADD:      alu_out = op_a + op_b;
            ALU_SUB:      alu_out = op_a - op_b;
            ALU_AND:      alu_out = op_a & op_b;
            ALU_OR:       alu_out = op_a | op_b;
            ALU_XOR:      alu_out = op_a ^ op_b;
            ALU_SLL:      alu_out = op_a << op_b[4:0];
            ALU_SRL:      alu_out = op_a >> op_b[4:0];
            ALU_SRA:      alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_SLT:      alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:     alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_A_PLUS_4: alu_out = op_a + 32'd4;
            ALU_BSEL:     alu_out = op_b;
            default:      alu_out = '0;
        endcase
    end

    // On a mispredict the ALU already holds the corrected fetch address
    assign redirect    = ex_valid && br_mispred;
    assign redirect_pc = alu_out;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tohost     <= '0;
            mem_valid  <= 1'b0;
            mem_inst_q <= '0;
        end else begin
            if (ex_valid && csr_en && ex_inst[31:20] == CSR_TOHOST) begin
                tohost <= (csr_mux_sel == CSR_IMM) ? ex_imm : rs1;
            end
            mem_valid  <= ex_valid;
            mem_inst_q <= ex_inst;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu        <= alu_out;
        mem_store_data <= rs2;
    end

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    mem_valid,
    input  logic [31:0]             mem_inst,
    input  logic [rv_pkg::XLEN-1:0] mem_alu,
    input  logic [rv_pkg::XLEN-1:0] mem_store_data,
    output logic [rv_pkg::XLEN-1:0] mem_fwd_val,
    output logic                    wb_valid,
    output logic [31:0]             wb_inst,
    output logic [4:0]              wb_rd,
    output logic [rv_pkg::XLEN-1:0] wb_data
);
    import rv_pkg::*;

    logic [XLEN-1:0]               dmem [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0] word_addr;
    opcode_e                       opcode;
    logic                          writes_rd;

    assign opcode    = opcode_e'(mem_inst[6:0]);
    assign word_addr = mem_alu[7:2];

    // All widths act as full words
    always_ff @(posedge clk) begin
        if (mem_valid && opcode == OPC_STORE) begin
            dmem[word_addr] <= mem_store_data;
        end
    end

    assign mem_fwd_val = (opcode == OPC_LOAD) ? dmem[word_addr] : mem_alu;

    assign writes_rd = opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD,
                                      OPC_ARI_ITYPE, OPC_ARI_RTYPE} && mem_inst[11:7] != 5'd0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            wb_inst  <= '0;
        end else begin
            wb_valid <= mem_valid && writes_rd;
            wb_inst  <= mem_inst;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_inst[11:7];
        wb_data <= mem_fwd_val;
    end

endmodule

// ==== verilog/rv_backend.sv ====
`timescale 1ns/1ps

module rv_backend (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  logic [31:0]             inst,
    input  logic [rv_pkg::XLEN-1:0] pc,
    input  logic                    pred_taken,
    output logic                    redirect,
    output logic [rv_pkg::XLEN-1:0] redirect_pc,
    output logic                    wb_valid,
    output logic [4:0]              wb_rd,
    output logic [rv_pkg::XLEN-1:0] wb_data,
    output logic [rv_pkg::XLEN-1:0] tohost
);
    import rv_pkg::*;

    logic            ex_valid;
    logic [31:0]     ex_inst;
    logic [XLEN-1:0] ex_pc;
    logic            ex_pred_taken;
    logic [XLEN-1:0] ex_rs1_val;
    logic [XLEN-1:0] ex_rs2_val;
    logic [XLEN-1:0] ex_imm;
    logic            mem_valid;
    logic [31:0]     mem_inst;
    logic [XLEN-1:0] mem_alu;
    logic [XLEN-1:0] mem_store_data;
    logic [XLEN-1:0] mem_fwd_val;
    logic [31:0]     wb_inst;

    // Redirect squashes the instruction entering decode
    decode_stage decode_i (
        .clk (clk), .arst_n (arst_n), .in_valid (in_valid), .inst (inst), .pc (pc),
        .pred_taken (pred_taken), .kill (redirect),
        .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data),
        .ex_valid (ex_valid), .ex_inst (ex_inst), .ex_pc (ex_pc),
        .ex_pred_taken (ex_pred_taken), .ex_rs1_val (ex_rs1_val),
        .ex_rs2_val (ex_rs2_val), .ex_imm (ex_imm)
    );

    execute_stage execute_i (
        .clk (clk), .arst_n (arst_n), .ex_valid (ex_valid), .ex_inst (ex_inst),
        .ex_pc (ex_pc), .ex_pred_taken (ex_pred_taken), .ex_rs1_val (ex_rs1_val),
        .ex_rs2_val (ex_rs2_val), .ex_imm (ex_imm), .mem_fwd_val (mem_fwd_val),
        .wb_fwd_val (wb_data), .mem_inst (mem_inst), .wb_inst (wb_inst),
        .mem_valid (mem_valid), .mem_inst_q (mem_inst), .mem_alu (mem_alu),
        .mem_store_data (mem_store_data), .redirect (redirect),
        .redirect_pc (redirect_pc), .tohost (tohost)
    );

    mem_stage mem_i (
        .clk (clk), .arst_n (arst_n), .mem_valid (mem_valid), .mem_inst (mem_inst),
        .mem_alu (mem_alu), .mem_store_data (mem_store_data),
        .mem_fwd_val (mem_fwd_val), .wb_valid (wb_valid), .wb_inst (wb_inst),
        .wb_rd (wb_rd), .wb_data (wb_data)
    );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a rising edge after the reset window
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// ==== testbench/rv_backend_tb.sv ====
`timescale 1ns/1ps

module rv_backend_tb;
    import rv_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int MAX_ENTRIES  = 40;

    // What an entry is expected to do once issued
    typedef enum {RETIRE, QUIET, REDIRECT, SQUASHED, CSR_WRITE} kind_e;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        pred_taken;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [31:0] tohost;

    string       tbl_name   [MAX_ENTRIES];
    logic [31:0] tbl_inst   [MAX_ENTRIES];
    logic [31:0] tbl_pc     [MAX_ENTRIES];
    logic        tbl_pred   [MAX_ENTRIES];
    kind_e       tbl_kind   [MAX_ENTRIES];
    logic [31:0] tbl_val    [MAX_ENTRIES];
    int          issue_cyc  [MAX_ENTRIES];
    int          entry_errs [MAX_ENTRIES];
    int          retire_list [$];

    int n_entries = 0;
    int ret_ptr   = 0;
    int cycle     = 0;
    int errors    = 0;
    int passed    = 0;
    int failed    = 0;

    tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv_backend dut_i (.*);

    // RV32I instruction formats
    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_ARI_RTYPE};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                           input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic add_entry(input string name, input logic [31:0] word, input int pred,
                             input kind_e kind, input logic [31:0] value);
        tbl_name[n_entries]   = name;
        tbl_inst[n_entries]   = word;
        tbl_pc[n_entries]     = 32'h100 + 4 * n_entries;
        tbl_pred[n_entries]   = pred != 0;
        tbl_kind[n_entries]   = kind;
        tbl_val[n_entries]    = value;
        entry_errs[n_entries] = 0;
        if (kind == RETIRE) begin
            retire_list.push_back(n_entries);
        end
        n_entries++;
    endtask

    task automatic note_mismatch(input int idx, input string msg);
        errors++;
        entry_errs[idx]++;
        $display("mismatch at %0t: test %0d %s: %s", $time, idx, tbl_name[idx], msg);
    endtask

    task automatic note_failure(input int idx, input string msg);
        errors++;
        entry_errs[idx]++;
        $display("test %0d %s: %s", idx, tbl_name[idx], msg);
    endtask

    task automatic finish_entry(input int idx);
        if (entry_errs[idx] == 0) begin
            passed++;
            $display("test %0d %s: ok", idx, tbl_name[idx]);
        end else begin
            failed++;
            $display("test %0d %s: failed, %0d errors", idx, tbl_name[idx], entry_errs[idx]);
        end
    endtask

    task automatic build_table();
        // Dependent chain through MEM, WB and the register write-through
        add_entry("addi x1", i_type(5, 0, FNC_ADD_SUB, 1, OPC_ARI_ITYPE), 0, RETIRE, 5);
        add_entry("addi x2", i_type(-3, 0, FNC_ADD_SUB, 2, OPC_ARI_ITYPE), 0, RETIRE, 'hfffffffd);
        add_entry("add", r_type(0, 2, 1, FNC_ADD_SUB, 3), 0, RETIRE, 2);
        add_entry("sub", r_type('h20, 1, 3, FNC_ADD_SUB, 4), 0, RETIRE, 'hfffffffd);
        add_entry("xor", r_type(0, 1, 4, FNC_XOR, 5), 0, RETIRE, 'hfffffff8);
        add_entry("slli", i_type(3, 1, FNC_SLL, 6, OPC_ARI_ITYPE), 0, RETIRE, 'h28);
        add_entry("srai", i_type('h401, 2, FNC_SRL_SRA, 7, OPC_ARI_ITYPE), 0, RETIRE, 'hfffffffe);
        add_entry("srli", i_type(4, 5, FNC_SRL_SRA, 8, OPC_ARI_ITYPE), 0, RETIRE, 'h0fffffff);
        add_entry("slt", r_type(0, 1, 2, FNC_SLT, 9), 0, RETIRE, 1);
        add_entry("sltu", r_type(0, 1, 2, FNC_SLTU, 10), 0, RETIRE, 0);
        // Store then load of the same word, load result forwarded
        add_entry("addi x11", i_type('h40, 0, FNC_ADD_SUB, 11, OPC_ARI_ITYPE), 0, RETIRE, 'h40);
        add_entry("sw", s_type(8, 6, 11, FNC_SW), 0, QUIET, 0);
        add_entry("lw", i_type(8, 11, FNC_LW, 12, OPC_LOAD), 0, RETIRE, 'h28);
        add_entry("add after lw", r_type(0, 1, 12, FNC_ADD_SUB, 13), 0, RETIRE, 'h2d);
        // Correctly predicted branches
        add_entry("beq", b_type(8, 1, 1, FNC_BEQ), 1, QUIET, 0);
        add_entry("bne", b_type(8, 1, 1, FNC_BNE), 0, QUIET, 0);
        add_entry("blt", b_type(12, 1, 2, FNC_BLT), 1, QUIET, 0);
        add_entry("bge", b_type(12, 1, 2, FNC_BGE), 0, QUIET, 0);
        add_entry("bltu", b_type(16, 1, 2, FNC_BLTU), 0, QUIET, 0);
        add_entry("bgeu", b_type(16, 1, 2, FNC_BGEU), 1, QUIET, 0);
        add_entry("addi x14", i_type(7, 0, FNC_ADD_SUB, 14, OPC_ARI_ITYPE), 0, RETIRE, 7);
        // Mispredicts, each followed by a wrong-path instruction
        add_entry("bne taken", b_type('h20, 2, 1, FNC_BNE), 0, REDIRECT, 'h154 + 'h20);
        add_entry("wrong path 1", i_type(1, 0, FNC_ADD_SUB, 15, OPC_ARI_ITYPE), 0, SQUASHED, 0);
        add_entry("beq not taken", b_type('h20, 2, 1, FNC_BEQ), 1, REDIRECT, 'h15c + 4);
        add_entry("wrong path 2", i_type(2, 0, FNC_ADD_SUB, 15, OPC_ARI_ITYPE), 0, SQUASHED, 0);
        add_entry("lui", u_type('h12345, 16, OPC_LUI), 0, RETIRE, 'h12345000);
        add_entry("auipc", u_type(1, 17, OPC_AUIPC), 0, RETIRE, 'h168 + 'h1000);
        add_entry("jal", j_type(16, 18), 0, RETIRE, 'h16c + 4);
        add_entry("jalr", i_type(0, 1, 3'b000, 19, OPC_JALR), 0, RETIRE, 'h170 + 4);
        add_entry("csrrw", i_type(CSR_TOHOST, 13, FNC_CSRRW, 20, OPC_CSR), 0, CSR_WRITE, 'h2d);
        add_entry("csrrwi", i_type(CSR_TOHOST, 'h1b, FNC_CSRRWI, 21, OPC_CSR), 0, CSR_WRITE, 'h1b);
    endtask

    task automatic check_redirect(input int idx);
        if (tbl_kind[idx] == REDIRECT) begin
            if (redirect !== 1'b1) begin
                note_failure(idx, "mispredicted branch raised no redirect");
            end else if (redirect_pc !== tbl_val[idx]) begin
                note_mismatch(idx, $sformatf("redirect_pc 0x%08h, expected 0x%08h",
                                             redirect_pc, tbl_val[idx]));
            end
        end else if (redirect !== 1'b0) begin
            note_failure(idx, "redirect raised where none was due");
        end
    endtask

    task automatic check_tohost(input int idx);
        if (tbl_kind[idx] == CSR_WRITE) begin
            if (tohost !== tbl_val[idx]) begin
                note_mismatch(idx, $sformatf("tohost 0x%08h, expected 0x%08h",
                                             tohost, tbl_val[idx]));
            end
        end
    endtask

    // Called in the cycle where the entry would show on wb_valid
    task automatic check_no_retire(input int idx);
        if (tbl_kind[idx] != RETIRE) begin
            if (wb_valid !== 1'b0) begin
                note_failure(idx, "wb_valid raised where no retire was due");
            end
            finish_entry(idx);
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= RESET_CYCLES + n_entries + 10) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Retires must come in table order, three edges after acceptance
    always @(negedge clk) begin : retire_check
        int idx;
        if (arst_n && wb_valid) begin
            if (ret_ptr >= retire_list.size()) begin
                errors++;
                $display("retire of x%0d seen with no instruction left to retire", wb_rd);
            end else begin
                idx = retire_list[ret_ptr];
                ret_ptr++;
                if (cycle != issue_cyc[idx] + 3) begin
                    note_failure(idx, "retired in the wrong cycle");
                end
                if (wb_rd !== tbl_inst[idx][11:7] || wb_data !== tbl_val[idx]) begin
                    note_mismatch(idx, $sformatf("retired x%0d = 0x%08h, expected x%0d = 0x%08h",
                                                 wb_rd, wb_data, tbl_inst[idx][11:7],
                                                 tbl_val[idx]));
                end
                finish_entry(idx);
            end
        end
    end

    initial begin
        in_valid   = 1'b0;
        inst       = '0;
        pc         = '0;
        pred_taken = 1'b0;
        build_table();
        wait (arst_n === 1'b1);

        for (int j = 0; j < n_entries + 3; j++) begin
            @(posedge clk);
            if (j < n_entries) begin
                in_valid   <= 1'b1;
                inst       <= tbl_inst[j];
                pc         <= tbl_pc[j];
                pred_taken <= tbl_pred[j];
            end else begin
                in_valid   <= 1'b0;
                inst       <= '0;
                pred_taken <= 1'b0;
            end
            @(negedge clk);
            if (j < n_entries) begin
                issue_cyc[j] = cycle;
            end
            if (j >= 1 && j <= n_entries) begin
                check_redirect(j - 1);
            end
            if (j >= 2 && j <= n_entries + 1) begin
                check_tohost(j - 2);
            end
            if (j >= 3) begin
                check_no_retire(j - 3);
            end
        end

        // Latency is fixed, so the last issue bounds the drain
        while (cycle <= issue_cyc[n_entries - 1] + 3) begin
            @(negedge clk);
        end
        for (int k = ret_ptr; k < retire_list.size(); k++) begin
            note_failure(retire_list[k], "instruction never retired");
            finish_entry(retire_list[k]);
        end

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 n_entries, passed, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/rv_pkg.sv
verilog/ex_control.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/rv_backend.sv
testbench/tb_clock.sv
testbench/rv_backend_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = rv_backend_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
